//--- run_sim.sh
#!/bin/sh
# build and run the QL bus glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module ql_bus_glue_tb \
	-f verilog.f -o ql_bus_glue_sim

# assertion errors must not stop the run early, the testbench reports them
./obj_dir/ql_bus_glue_sim +verilator+error+limit+100000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
	echo "simulation result: pass"
else
	echo "simulation result: fail"
	exit 1
fi

//--- verification/ql_bus_glue_properties.sv
/*
  bound checker for the QL bus glue
  expected values are rebuilt from the bus rules, fail_count holds the failures
  reset stretch check starts after the first trigger has been seen
*/
module ql_bus_glue_properties
	import ql_bus_pkg::*;
(
	input logic              clk2,
	input logic              rst_n,
	input logic              ext_reset,
	input logic              ram_640k,
	input cpu_bus_t          cpu,
	input dio_t              dio,
	input video_req_t        vreq,
	input periph_rd_t        periph,
	input logic [data_w-1:0] sdram_dout,
	input sdram_req_t        sdram_req,
	input logic [data_w-1:0] cpu_din,
	input logic              cpu_enable,
	input logic              sys_reset,
	input logic              video_cycle,
	input periph_sel_t       sel
);

	int unsigned fail_count = 0;

	logic        act;
	logic        rd;
	logic        wr;
	logic        rom;
	logic        io;
	logic        ram;
	logic        mem;
	logic        qimi;
	logic        trigger;
	logic        trig_seen = 1'b0;
	logic [12:0] since_trig = '0;	// saturating count of cycles since the last trigger edge
	logic        exp_sys_reset;
	logic        prev_vc = 1'b0;
	logic        prev_rst_n = 1'b0;
	logic        exp_enable;
	periph_sel_t exp_sel;
	sdram_req_t  exp_req;
	logic [15:0] exp_din;

	// ----------------------------------------
	// reference decode from address ranges
	// ----------------------------------------
	always_comb begin
		act  = (cpu.state == bus_fetch) || (cpu.state == bus_read) ||
			(cpu.state == bus_write);
		rd   = (cpu.state == bus_fetch) || (cpu.state == bus_read);
		wr   = (cpu.state == bus_write) && !cpu.rw_n;
		rom  = act && (cpu.addr <= 20'h0ffff);
		io   = act && (cpu.addr >= 20'h18000) && (cpu.addr <= 20'h1bfff);
		ram  = act && ((cpu.addr >= 20'h20000 && cpu.addr <= 20'h3ffff) ||
			(ram_640k && cpu.addr >= 20'h40000 && cpu.addr <= 20'hbffff));
		mem  = rom || ram;
		qimi = io && (cpu.addr[13:8] == 6'b111111);	// mouse at $1bfxx

		exp_sel.qlsd_rd    = rom && (cpu.addr[15:0] == 16'hfee4);
		exp_sel.zx8302_sel = !video_cycle && io && !cpu.addr[6];
		exp_sel.zx8301_sel = !video_cycle && io && wr && cpu.lds &&
			cpu.addr[6] && cpu.addr[5] && cpu.addr[1];
		exp_sel.qimi_sel   = qimi;

		// read data priority is ql-sd then sdram then io then open bus
		if (exp_sel.qlsd_rd)
			exp_din = {periph.qlsd_dout, periph.qlsd_dout};
		else if (mem)
			exp_din = sdram_dout;
		else if (io && qimi)
			exp_din = {periph.qimi_data, periph.qimi_data};
		else if (io)
			exp_din = cpu.addr[6] ? 16'h0000 : periph.zx8302_dout;
		else
			exp_din = 16'hffff;

		exp_enable = (!video_cycle && !dio.download) || (cpu.state == bus_idle);
	end

	// expected sdram request for either slot
	always_comb begin
		exp_req = '0;
		if (video_cycle) begin
			exp_req.uds = 1'b1;
			exp_req.lds = 1'b1;
			if (vreq.mdv1_read || vreq.mdv2_read) begin
				exp_req.addr = vreq.mdv_seldrive ? vreq.mdv2_addr : vreq.mdv1_addr;
				exp_req.oe   = 1'b1;
			end else begin
				exp_req.addr = {6'b000000, vreq.video_addr};
				exp_req.oe   = vreq.video_rd;
			end
		end else if (dio.download) begin
			exp_req.addr = dio.addr;
			exp_req.din  = dio.data;
			exp_req.wr   = dio.write;
			exp_req.uds  = 1'b1;
			exp_req.lds  = 1'b1;
		end else begin
			exp_req.addr = {6'b000000, cpu.addr[19:1]};	// word address
			exp_req.din  = cpu.dout;
			exp_req.wr   = wr && ram;
			exp_req.oe   = rd && mem;
			exp_req.uds  = cpu.uds;
			exp_req.lds  = cpu.lds;
		end
	end

	// ----------------------------------------
	// reset stretch reference
	// ----------------------------------------
	assign trigger = !rst_n || ext_reset ||
		(dio.download && (dio.index == dl_rom || dio.index == dl_ext_rom));
	assign exp_sys_reset = since_trig < 13'd4095;	// high for reset_hold cycles

	always @(posedge clk2) begin
		prev_vc    <= video_cycle;
		prev_rst_n <= rst_n;
		if (trigger) begin
			since_trig <= '0;
			trig_seen  <= 1'b1;
		end else if (since_trig != 13'h1fff) begin
			since_trig <= since_trig + 13'd1;
		end
	end

	// ----------------------------------------
	// assertions
	// ----------------------------------------
	a_sys_reset: assert property (@(posedge clk2) trig_seen |-> sys_reset == exp_sys_reset)
		else begin
			$error("CHECK FAILED t=%0t sys_reset got %b expected %b", $time,
				$sampled(sys_reset), $sampled(exp_sys_reset));
			fail_count++;
		end

	a_first_slot: assert property (@(posedge clk2) rst_n && !prev_rst_n |-> !video_cycle)
		else begin
			$error("CHECK FAILED t=%0t video_cycle got %b expected 0", $time,
				$sampled(video_cycle));
			fail_count++;
		end

	a_slot_toggle: assert property (@(posedge clk2)
		rst_n && prev_rst_n |-> video_cycle == !prev_vc)
		else begin
			$error("CHECK FAILED t=%0t video_cycle got %b expected %b", $time,
				$sampled(video_cycle), !$sampled(prev_vc));
			fail_count++;
		end

	a_req_addr: assert property (@(posedge clk2) disable iff (!rst_n)
		sdram_req.addr == exp_req.addr)
		else begin
			$error("CHECK FAILED t=%0t sdram_req.addr got %h expected %h", $time,
				$sampled(sdram_req.addr), $sampled(exp_req.addr));
			fail_count++;
		end

	// wr, oe, uds, lds as one nibble
	a_req_ctrl: assert property (@(posedge clk2) disable iff (!rst_n)
		sdram_req[3:0] == exp_req[3:0])
		else begin
			$error("CHECK FAILED t=%0t sdram_req.ctrl got %b expected %b", $time,
				$sampled(sdram_req[3:0]), $sampled(exp_req[3:0]));
			fail_count++;
		end

	// din only matters in the cpu slot
	a_req_din: assert property (@(posedge clk2) disable iff (!rst_n)
		!video_cycle |-> sdram_req.din == exp_req.din)
		else begin
			$error("CHECK FAILED t=%0t sdram_req.din got %h expected %h", $time,
				$sampled(sdram_req.din), $sampled(exp_req.din));
			fail_count++;
		end

	a_sel: assert property (@(posedge clk2) disable iff (!rst_n) sel == exp_sel)
		else begin
			$error("CHECK FAILED t=%0t sel got %b expected %b", $time,
				$sampled(sel), $sampled(exp_sel));
			fail_count++;
		end

	a_cpu_din: assert property (@(posedge clk2) disable iff (!rst_n) cpu_din == exp_din)
		else begin
			$error("CHECK FAILED t=%0t cpu_din got %h expected %h", $time,
				$sampled(cpu_din), $sampled(exp_din));
			fail_count++;
		end

	a_cpu_enable: assert property (@(posedge clk2) disable iff (!rst_n)
		cpu_enable == exp_enable)
		else begin
			$error("CHECK FAILED t=%0t cpu_enable got %b expected %b", $time,
				$sampled(cpu_enable), $sampled(exp_enable));
			fail_count++;
		end

endmodule

//--- verification/ql_bus_glue_tb.sv
/*
  testbench for the QL bus glue with fixed seed random stimulus
  inputs change on the falling edge and the bound properties hold the checks
  three full reset stretches make the run about 16k cycles long
*/
module ql_bus_glue_tb
	import ql_bus_pkg::*;
();

	localparam int random_cycles = 3000;
	// three reset windows with margin, the random test, and spare
	localparam int max_cycles = 3 * (int'(reset_hold) + 200) + random_cycles + 3000;

	logic              clk2 = 1'b0;
	logic              rst_n;
	logic              ext_reset;
	logic              ram_640k;
	cpu_bus_t          cpu;
	dio_t              dio;
	video_req_t        vreq;
	periph_rd_t        periph;
	logic [data_w-1:0] sdram_dout;
	sdram_req_t        sdram_req;
	logic [data_w-1:0] cpu_din;
	logic              cpu_enable;
	logic              sys_reset;
	logic              video_cycle;
	periph_sel_t       sel;

	int unsigned cycle_count = 0;
	int unsigned fails_seen = 0;
	int unsigned tests_run = 0;
	int unsigned tests_failed = 0;

	ql_bus_glue ql_bus_glue_i (.*);

	bind ql_bus_glue ql_bus_glue_properties check_i (.*);

	always #10 clk2 = !clk2;	// 20 unit period

	// run limit
	always @(posedge clk2) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ----------------------------------------
	// stimulus helpers
	// ----------------------------------------
	// addresses aimed at each region and the special registers
	function automatic logic [19:0] pick_address();
		logic [31:0] r;
		r = $urandom;
		case ($urandom_range(8, 0))
			0: return {4'h0, r[15:0]};	// rom
			1: return 20'h0fee4;	// ql-sd register
			2: return {6'h06, r[13:0]};	// io
			3: return {12'h1bf, r[7:0]};	// qimi
			4: return {19'h0c031, r[0]};	// zx8301 at $18062/3
			5: return {3'b001, r[16:0]};	// base ram
			6: return {r[19] ? 2'b10 : 2'b01, r[17:0]};	// extended ram
			7: return {2'b11, r[17:0]};	// unmapped top
			default: return {4'h1, r[15:0]};	// gap around io
		endcase
	endfunction

	task automatic drive_traffic();
		logic [127:0] r;
		r = {$urandom, $urandom, $urandom, $urandom};
		cpu.addr   = pick_address();
		cpu.dout   = r[127:112];
		cpu.uds    = r[121];
		cpu.lds    = r[122];
		cpu.state  = bus_state_e'(r[124:123]);
		cpu.rw_n   = r[125];
		vreq       = video_req_t'(r[72:0]);
		if (vreq.mdv1_read && vreq.mdv2_read)
			vreq.mdv2_read = 1'b0;	// only one drive reads at a time
		periph     = periph_rd_t'(r[104:73]);
		sdram_dout = r[120:105];
	endtask

	task automatic wait_reset_release();
		while (sys_reset) begin	// sys_reset is stable on the falling edge
			drive_traffic();
			@(negedge clk2);
		end
	endtask

	task automatic close_test(input string name);
		int unsigned fails;
		fails      = ql_bus_glue_i.check_i.fail_count - fails_seen;
		fails_seen = ql_bus_glue_i.check_i.fail_count;
		tests_run++;
		if (fails == 0) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d assertion failures", name, fails);
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		void'($urandom(32'h93d3487d));
		rst_n      = 1'b0;
		ext_reset  = 1'b0;
		ram_640k   = 1'b0;
		cpu        = '0;
		cpu.state  = bus_idle;
		dio        = '0;
		vreq       = '0;
		periph     = '0;
		sdram_dout = '0;
		repeat (10) @(negedge clk2);
		rst_n = 1'b1;

		wait_reset_release();	// stretch after board reset
		close_test("reset after rst_n");

		ext_reset = 1'b1;
		drive_traffic();
		@(negedge clk2);
		ext_reset = 1'b0;
		wait_reset_release();
		close_test("ext_reset pulse");

		// rom then extended rom image with sys_reset held 4095 cycles after the last word
		for (int i = 0; i < 40; i++) begin
			dio.download = 1'b1;
			dio.index    = (i < 20) ? dl_rom : dl_ext_rom;
			dio.addr     = sdram_addr_w'($urandom);
			dio.data     = data_w'($urandom);
			dio.write    = 1'(($urandom));
			drive_traffic();
			@(negedge clk2);
		end
		dio = '0;
		wait_reset_release();
		close_test("rom download");

		// microdrive images must leave sys_reset low
		for (int i = 0; i < 60; i++) begin
			dio.download = (i < 40);
			dio.index    = (i < 20) ? dl_mdv1 : dl_mdv2;
			dio.addr     = sdram_addr_w'($urandom);
			dio.data     = data_w'($urandom);
			dio.write    = 1'(($urandom));
			drive_traffic();
			@(negedge clk2);
		end
		dio = '0;
		close_test("microdrive download");

		for (int i = 0; i < random_cycles; i++) begin
			if (i % 100 == 0)
				ram_640k = !ram_640k;	// extended ram on and off
			drive_traffic();
			@(negedge clk2);
		end
		close_test("random cpu and video traffic");

		$display("tests run %0d, tests failed %0d, assertion failures %0d",
			tests_run, tests_failed, fails_seen);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
verilog/ql_bus_pkg.sv
verilog/ql_reset_gen.sv
verilog/ql_addr_decode.sv
verilog/ql_slot_arbiter.sv
verilog/ql_read_mux.sv
verilog/ql_bus_glue.sv
verification/ql_bus_glue_properties.sv
verification/ql_bus_glue_tb.sv

//--- verilog/ql_addr_decode.sv
/*
  cpu address decoder for the QL memory map
  purely combinational, regions only assert while the bus is active
  extended ram at $40000-$bffff needs ram_640k
*/
module ql_addr_decode
	import ql_bus_pkg::*;
(
	input  cpu_bus_t    cpu,
	input  logic        ram_640k,
	input  logic        video_cycle,
	output region_t     region,
	output periph_sel_t sel
);

	logic act;
	logic wr;
	logic bram;
	logic xram;
	logic cpu_cycle;

	assign cpu_cycle = !video_cycle;

	// ----------------------------------------
	// bus activity
	// ----------------------------------------
	assign act = (cpu.state != bus_idle);	// fetch, read or write
	assign wr  = (cpu.state == bus_write) && !cpu.rw_n;

	// ----------------------------------------
	// memory regions
	// ----------------------------------------
	assign bram = (cpu.addr[19:17] == bram_page);
	assign xram = ram_640k &&
		(cpu.addr[19:18] == xram_lo || cpu.addr[19:18] == xram_hi);

	always_comb begin
		region.act = act;
		region.wr  = wr;
		region.rom = act && (cpu.addr[19:16] == rom_page);
		region.io  = act && (cpu.addr[19:14] == io_page);
		region.ram = act && (bram || xram);
		region.mem = region.rom || region.ram;	// anything served by sdram
	end

	// ----------------------------------------
	// peripheral selects
	// ----------------------------------------
	always_comb begin
		// ql-sd sits inside the rom window
		sel.qlsd_rd = region.rom && (cpu.addr[15:0] == qlsd_reg_addr);

		// zx8302 owns the lower half of each io page
		sel.zx8302_sel = cpu_cycle && region.io && !cpu.addr[6];

		// single write-only zx8301 register at $18063
		sel.zx8301_sel = cpu_cycle && region.io && wr && cpu.lds &&
			({cpu.addr[6], cpu.addr[5], cpu.addr[1]} == zx8301_reg);

		sel.qimi_sel = region.io && (cpu.addr[13:8] == qimi_page);	// no slot term
	end

endmodule

//--- verilog/ql_bus_glue.sv
/*
  QL system bus glue top level
  cpu, video, peripherals and sdram controller sit outside and connect
  through the struct ports, everything runs on clk2
*/
module ql_bus_glue
	import ql_bus_pkg::*;
(
	input  logic              clk2,
	input  logic              rst_n,
	input  logic              ext_reset,
	input  logic              ram_640k,	// enables extended ram
	input  cpu_bus_t          cpu,
	input  dio_t              dio,
	input  video_req_t        vreq,
	input  periph_rd_t        periph,
	input  logic [data_w-1:0] sdram_dout,
	output sdram_req_t        sdram_req,
	output logic [data_w-1:0] cpu_din,
	output logic              cpu_enable,
	output logic              sys_reset,
	output logic              video_cycle,
	output periph_sel_t       sel
);

	region_t region;	// decode result shared by arbiter and read mux

	// ----------------------------------------
	// reset
	// ----------------------------------------
	ql_reset_gen u_reset_gen (
		.clk2      (clk2),
		.rst_n     (rst_n),
		.ext_reset (ext_reset),
		.dio       (dio),
		.sys_reset (sys_reset)
	);

	// ----------------------------------------
	// decode and slots
	// ----------------------------------------
	ql_addr_decode u_addr_decode (
		.cpu         (cpu),
		.ram_640k    (ram_640k),
		.video_cycle (video_cycle),
		.region      (region),
		.sel         (sel)
	);

	ql_slot_arbiter u_slot_arbiter (
		.clk2        (clk2),
		.rst_n       (rst_n),
		.cpu         (cpu),
		.dio         (dio),
		.vreq        (vreq),
		.region      (region),
		.sdram_req   (sdram_req),
		.cpu_enable  (cpu_enable),
		.video_cycle (video_cycle)
	);

	// read data back to the cpu
	ql_read_mux u_read_mux (
		.region     (region),
		.sel        (sel),
		.addr6      (cpu.addr[6]),
		.periph     (periph),
		.sdram_dout (sdram_dout),
		.cpu_din    (cpu_din)
	);

endmodule

//--- verilog/ql_bus_pkg.sv
/*
  shared types and constants for the QL system bus glue
  widths are fixed by the QL memory map and have no module parameters
  struct fields are declared msb first
*/
package ql_bus_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int cpu_addr_w   = 20;	// 68008 style 1 MB space
	localparam int sdram_addr_w = 25;	// sdram word address
	localparam int video_addr_w = 19;	// zx8301 fetch word address
	localparam int data_w       = 16;
	localparam int reset_cnt_w  = 12;

	// number of clk2 cycles the cpu is held in reset
	localparam logic [reset_cnt_w-1:0] reset_hold = 12'd4095;

	// ----------------------------------------
	// memory map, compared against the upper address bits
	// ----------------------------------------
	localparam logic [3:0] rom_page   = 4'h0;	// addr[19:16], 64k rom at $00000
	localparam logic [5:0] io_page    = 6'h06;	// addr[19:14], io at $18000-$1bfff
	localparam logic [2:0] bram_page  = 3'b001;	// addr[19:17], 128k ram at $20000
	localparam logic [1:0] xram_lo    = 2'b01;	// addr[19:18], extended ram $40000
	localparam logic [1:0] xram_hi    = 2'b10;	// addr[19:18], up to $bffff
	localparam logic [5:0] qimi_page  = 6'h3f;	// addr[13:8], mouse at $1bfxx
	localparam logic [2:0] zx8301_reg = 3'b111;	// {addr6, addr5, addr1}

	localparam logic [15:0] qlsd_reg_addr = 16'hfee4;	// only readable ql-sd register
	localparam logic [data_w-1:0] open_bus = 16'hffff;

	// ----------------------------------------
	// enums
	// ----------------------------------------
	// encoding matches the tg68 busstate output
	typedef enum logic [1:0] {
		bus_fetch = 2'b00,
		bus_idle  = 2'b01,
		bus_read  = 2'b10,
		bus_write = 2'b11
	} bus_state_e;

	typedef enum logic [4:0] {
		dl_rom     = 5'd0,
		dl_mdv1    = 5'd1,
		dl_mdv2    = 5'd2,
		dl_ext_rom = 5'd3
	} dl_index_e;

	// ----------------------------------------
	// bus structs
	// ----------------------------------------
	typedef struct packed {
		logic [cpu_addr_w-1:0] addr;
		logic [data_w-1:0]     dout;
		logic                  uds;	// active high strobes
		logic                  lds;
		bus_state_e            state;
		logic                  rw_n;
	} cpu_bus_t;

	typedef struct packed {
		logic                    download;
		dl_index_e               index;
		logic [sdram_addr_w-1:0] addr;
		logic [data_w-1:0]       data;
		logic                    write;
	} dio_t;

	// requesters sharing the video slot, only one drive reads at a time
	typedef struct packed {
		logic [video_addr_w-1:0] video_addr;
		logic                    video_rd;
		logic                    mdv1_read;
		logic                    mdv2_read;
		logic                    mdv_seldrive;	// 1 selects mdv2
		logic [sdram_addr_w-1:0] mdv1_addr;
		logic [sdram_addr_w-1:0] mdv2_addr;
	} video_req_t;

	typedef struct packed {
		logic [sdram_addr_w-1:0] addr;
		logic [data_w-1:0]       din;
		logic                    wr;
		logic                    oe;
		logic                    uds;
		logic                    lds;
	} sdram_req_t;

	typedef struct packed {
		logic io;
		logic rom;
		logic ram;
		logic mem;	// rom or ram, anything backed by sdram
		logic act;	// read or write in progress
		logic wr;	// data write
	} region_t;

	typedef struct packed {
		logic zx8301_sel;
		logic zx8302_sel;
		logic qimi_sel;
		logic qlsd_rd;
	} periph_sel_t;

	typedef struct packed {
		logic [7:0]        qimi_data;
		logic [data_w-1:0] zx8302_dout;
		logic [7:0]        qlsd_dout;
	} periph_rd_t;

endpackage

//--- verilog/ql_read_mux.sv
/*
  cpu read data multiplexer
  byte wide sources are duplicated into both halves of the word
  unmapped addresses read as the open bus value
*/
module ql_read_mux
	import ql_bus_pkg::*;
(
	input  region_t           region,
	input  periph_sel_t       sel,
	input  logic              addr6,
	input  periph_rd_t        periph,
	input  logic [data_w-1:0] sdram_dout,
	output logic [data_w-1:0] cpu_din
);

	logic [data_w-1:0] io_dout;

	// io space, mouse first then zx8302 lower half
	always_comb begin
		if (sel.qimi_sel) begin
			io_dout = {periph.qimi_data, periph.qimi_data};
		end else if (!addr6) begin
			io_dout = periph.zx8302_dout;
		end else begin
			io_dout = '0;	// upper half of io page reads zero
		end
	end

	// ql-sd overlays the rom window so it must win over sdram
	always_comb begin
		if (sel.qlsd_rd) begin
			cpu_din = {periph.qlsd_dout, periph.qlsd_dout};
		end else if (region.mem) begin
			cpu_din = sdram_dout;
		end else if (region.io) begin
			cpu_din = io_dout;
		end else begin
			cpu_din = open_bus;
		end
	end

endmodule

//--- verilog/ql_reset_gen.sv
/*
  system reset stretcher
  any trigger reloads the counter, so sys_reset stays high for the whole
  rom download and falls reset_hold cycles after the last trigger
*/
module ql_reset_gen
	import ql_bus_pkg::*;
(
	input  logic clk2,
	input  logic rst_n,
	input  logic ext_reset,	// button or menu reset
	input  dio_t dio,
	output logic sys_reset
);

	logic [reset_cnt_w-1:0] reset_cnt;
	logic                   rom_download;
	logic                   trigger;

	// only rom images restart the cpu, microdrive images do not
	assign rom_download = dio.download &&
		(dio.index == dl_rom || dio.index == dl_ext_rom);

	assign trigger = ext_reset || rom_download;

	// down counter, reloads on every trigger edge
	always_ff @(posedge clk2) begin
		if (!rst_n) begin
			reset_cnt <= reset_hold;	// board reset is a trigger too
		end else if (trigger) begin
			reset_cnt <= reset_hold;
		end else if (reset_cnt != '0) begin
			reset_cnt <= reset_cnt - 1'b1;
		end
	end

	assign sys_reset = (reset_cnt != '0);

endmodule

//--- verilog/ql_slot_arbiter.sv
/*
  sdram time slot arbiter
  cpu and video slots alternate every clk2 cycle, no back-pressure
  the cpu is stalled through cpu_enable and repeats its bus state
*/
module ql_slot_arbiter
	import ql_bus_pkg::*;
(
	input  logic       clk2,
	input  logic       rst_n,
	input  cpu_bus_t   cpu,
	input  dio_t       dio,
	input  video_req_t vreq,
	input  region_t    region,
	output sdram_req_t sdram_req,
	output logic       cpu_enable,
	output logic       video_cycle
);

	sdram_req_t cpu_slot_req;
	sdram_req_t video_slot_req;
	logic       cpu_rd;
	logic       mdv_read;

	// ----------------------------------------
	// slot toggle
	// ----------------------------------------
	always_ff @(posedge clk2) begin
		if (!rst_n) begin
			video_cycle <= 1'b0;	// first slot after reset goes to the cpu
		end else begin
			video_cycle <= !video_cycle;
		end
	end

	// cpu runs only in its own slot and never while a download owns it
	assign cpu_enable = (!video_cycle && !dio.download) || (cpu.state == bus_idle);

	assign cpu_rd = (cpu.state == bus_fetch) || (cpu.state == bus_read);

	// ----------------------------------------
	// cpu slot, download has priority over the cpu
	// ----------------------------------------
	always_comb begin
		if (dio.download) begin
			cpu_slot_req.addr = dio.addr;
			cpu_slot_req.din  = dio.data;
			cpu_slot_req.wr   = dio.write;
			cpu_slot_req.oe   = 1'b0;
			cpu_slot_req.uds  = 1'b1;	// full word writes
			cpu_slot_req.lds  = 1'b1;
		end else begin
			cpu_slot_req.addr = sdram_addr_w'(cpu.addr[cpu_addr_w-1:1]);	// word address
			cpu_slot_req.din  = cpu.dout;
			cpu_slot_req.wr   = region.wr && region.ram;	// rom is read only
			cpu_slot_req.oe   = cpu_rd && region.mem;
			cpu_slot_req.uds  = cpu.uds;
			cpu_slot_req.lds  = cpu.lds;
		end
	end

	// ----------------------------------------
	// video slot, microdrive before video fetch
	// ----------------------------------------
	assign mdv_read = vreq.mdv1_read || vreq.mdv2_read;

	always_comb begin
		video_slot_req.din = cpu_slot_req.din;	// don't care, never written
		video_slot_req.wr  = 1'b0;
		video_slot_req.uds = 1'b1;
		video_slot_req.lds = 1'b1;
		if (mdv_read) begin
			video_slot_req.addr = vreq.mdv_seldrive ? vreq.mdv2_addr : vreq.mdv1_addr;
			video_slot_req.oe   = 1'b1;
		end else begin
			video_slot_req.addr = sdram_addr_w'(vreq.video_addr);
			video_slot_req.oe   = vreq.video_rd;
		end
	end

	assign sdram_req = video_cycle ? video_slot_req : cpu_slot_req;

endmodule
